/* Makefile */
SIM := obj_dir/Vtb_fetch_top

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): fetch_front.f $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_fetch_top -Mdir obj_dir -f fetch_front.f

# The pipeline status is the status of grep
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -x "Result: PASSED" > /dev/null

clean:
	rm -rf obj_dir

/* fetch_front.f */
+incdir+rtl
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/icache.sv
rtl/fetch_unit.sv
rtl/predecode.sv
rtl/fetch_top.sv
verification/tb_axi_mem.sv
verification/tb_fetch_top.sv

/* rtl/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

//////////////////////////////////////////////////
// Fetch front end constants
//////////////////////////////////////////////////

`define FETCH_RESET_PC     32'h8000_0000
`define FETCH_INST_BYTES   4    // One RV32 instruction word

// Cache geometry, block may also be 8 or 32
`define FETCH_BLOCK_BYTES  16
`define ICACHE_SETS        16

`define FETCH_AXI_ID       4'h3 // Carried on every AR

`endif

/* rtl/fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

    localparam logic [6:0] OPC_JAL = 7'b1101111;

    //////////////////////////////////////////////////
    // AXI read channels
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

    //////////////////////////////////////////////////
    // Front end internals
    //////////////////////////////////////////////////

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic                             valid;
        logic [31:0]                      base;  // Block aligned
        logic [`FETCH_BLOCK_BYTES*8-1:0]  data;
    } fill_t;

    // Same word, two field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } generic;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jal;
    } rv32_inst_u;

    typedef struct packed {
        logic [31:0] pc;
        rv32_inst_u  inst;
        logic        access_fault;
    } fetch_out_t;

endpackage

/* rtl/fetch_top.sv */
module fetch_top (
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_pkg::redirect_t  redirect,
    output fetch_pkg::axi_ar_t    ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  fetch_pkg::axi_r_t     r,
    input  logic                  rvalid,
    output logic                  rready,
    output fetch_pkg::fetch_out_t dec_out,
    output logic                  dec_valid,
    input  logic                  dec_ready
);

    fetch_pkg::redirect_t  redirect_pd;
    fetch_pkg::fill_t      fill;
    fetch_pkg::fetch_out_t f_out;

    logic [31:0] pc;
    logic        pc_valid;
    logic        pc_taken;
    logic        flush;
    logic [31:0] lookup_addr;
    logic        lookup_en;
    logic        hit;
    logic [31:0] word;
    logic        f_valid;
    logic        f_ready;

    assign flush = redirect.valid | redirect_pd.valid;

    pc_gen u_pc_gen (
        .clk          (clk),
        .rst          (rst),
        .redirect_ext (redirect),
        .redirect_pd  (redirect_pd),
        .pc_taken     (pc_taken),
        .pc           (pc),
        .pc_valid     (pc_valid)
    );

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .pc_valid    (pc_valid),
        .pc_taken    (pc_taken),
        .flush       (flush),
        .lookup_addr (lookup_addr),
        .lookup_en   (lookup_en),
        .hit         (hit),
        .word        (word),
        .fill        (fill),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .f_out       (f_out),
        .f_valid     (f_valid),
        .f_ready     (f_ready)
    );

    icache u_icache (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .lookup_en   (lookup_en),
        .hit         (hit),
        .word        (word),
        .fill        (fill)
    );

    predecode u_predecode (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .f_out       (f_out),
        .f_valid     (f_valid),
        .f_ready     (f_ready),
        .dec_out     (dec_out),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .redirect_pd (redirect_pd)
    );

endmodule

/* rtl/fetch_unit.sv */
`include "fetch_consts.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           pc,
    input  logic                  pc_valid,
    output logic                  pc_taken,
    input  logic                  flush,
    output logic [31:0]           lookup_addr,
    output logic                  lookup_en,
    input  logic                  hit,
    input  logic [31:0]           word,
    output fetch_pkg::fill_t      fill,
    output fetch_pkg::axi_ar_t    ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  fetch_pkg::axi_r_t     r,
    input  logic                  rvalid,
    output logic                  rready,
    output fetch_pkg::fetch_out_t f_out,
    output logic                  f_valid,
    input  logic                  f_ready
);

    localparam int OFFSET_W  = $clog2(`FETCH_BLOCK_BYTES);
    localparam int INST_W    = $clog2(`FETCH_INST_BYTES);
    localparam int WORD_W    = OFFSET_W - INST_W;
    localparam int INST_BITS = `FETCH_INST_BYTES * 8;

    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        REFILL,
        HOLD
    } state_t;

    state_t                          state;
    logic [31:0]                     req_pc;
    logic [WORD_W-1:0]               word_idx;
    logic                            drop;       // Flushed during refill
    logic                            fill_valid;
    logic [`FETCH_BLOCK_BYTES*8-1:0] blk_q;
    logic [`FETCH_BLOCK_BYTES*8-1:0] blk_next;

    logic              beat;
    logic              beat_err;
    logic              last_word;
    logic              kill;
    logic [WORD_W-1:0] req_word;

    assign pc_taken    = (state == IDLE) && pc_valid && !flush;
    assign lookup_addr = pc;
    assign lookup_en   = pc_taken;

    assign beat      = rvalid && rready;
    assign beat_err  = r.resp != 2'b00;
    assign last_word = &word_idx;
    assign kill      = drop || flush;
    assign req_word  = req_pc[INST_W +: WORD_W];

    //////////////////////////////////////////////////
    // AR payload and fill
    //////////////////////////////////////////////////

    assign ar.addr  = {req_pc[31:OFFSET_W], word_idx, {INST_W{1'b0}}};
    assign ar.id    = `FETCH_AXI_ID;
    assign ar.len   = 8'd0;       // Single beat
    assign ar.size  = 3'(INST_W);
    assign ar.burst = 2'b01;      // INCR

    assign fill.valid = fill_valid;
    assign fill.base  = {req_pc[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign fill.data  = blk_q;

    // Current beat merged into the block buffer
    always_comb begin
        blk_next = blk_q;
        blk_next[word_idx*INST_BITS +: INST_BITS] = r.data;
    end

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            f_valid    <= 1'b0;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            fill_valid <= 1'b0;
            drop       <= 1'b0;
            word_idx   <= '0;
        end else begin
            fill_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (pc_taken) state <= CHECK;
                end
                CHECK: begin
                    if (flush) begin
                        state <= IDLE;
                    end else if (hit) begin
                        f_valid <= 1'b1;
                        state   <= HOLD;
                    end else begin
                        word_idx <= '0;
                        drop     <= 1'b0;
                        arvalid  <= 1'b1;
                        state    <= REFILL;
                    end
                end
                REFILL: begin
                    if (flush) drop <= 1'b1;
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (beat) begin
                        rready <= 1'b0;
                        if (beat_err || last_word) begin
                            fill_valid <= !beat_err;
                            f_valid    <= !kill;
                            state      <= kill ? IDLE : HOLD;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                            arvalid  <= 1'b1;   // Next word of the block
                        end
                    end
                end
                HOLD: begin
                    if (flush || f_ready) begin
                        f_valid <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pc_taken) req_pc <= pc;
        if (beat) blk_q <= blk_next;
        if (state == CHECK && hit) begin
            f_out.pc           <= req_pc;
            f_out.inst         <= word;
            f_out.access_fault <= 1'b0;
        end else if (state == REFILL && beat && (beat_err || last_word)) begin
            f_out.pc           <= req_pc;
            f_out.inst         <= beat_err ? '0 : blk_next[req_word*INST_BITS +: INST_BITS];
            f_out.access_fault <= beat_err;
        end
    end

    a_ar_stable: assert property (
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar)
    ) else $error("fetch_unit: AR changed before handshake");

    a_rid: assert property (
        @(posedge clk) disable iff (rst)
        rvalid && rready |-> (r.id == `FETCH_AXI_ID)
    ) else $error("fetch_unit: unexpected rid %h", r.id);

endmodule

/* rtl/icache.sv */
`include "fetch_consts.svh"

module icache (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      lookup_addr,
    input  logic             lookup_en,
    output logic             hit,
    output logic [31:0]      word,
    input  fetch_pkg::fill_t fill
);

    localparam int OFFSET_W  = $clog2(`FETCH_BLOCK_BYTES);
    localparam int INDEX_W   = $clog2(`ICACHE_SETS);
    localparam int TAG_W     = 32 - OFFSET_W - INDEX_W;
    localparam int INST_W    = $clog2(`FETCH_INST_BYTES);
    localparam int WORD_W    = OFFSET_W - INST_W;
    localparam int INST_BITS = `FETCH_INST_BYTES * 8;

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    logic [`ICACHE_SETS-1:0]         valid_q;
    logic [TAG_W-1:0]                tag_mem  [`ICACHE_SETS];
    logic [`FETCH_BLOCK_BYTES*8-1:0] data_mem [`ICACHE_SETS];

    logic [INDEX_W-1:0] lk_index;
    logic [TAG_W-1:0]   lk_tag;
    logic [WORD_W-1:0]  lk_word;
    logic [INDEX_W-1:0] fill_index;

    assign lk_index   = lookup_addr[OFFSET_W +: INDEX_W];
    assign lk_tag     = lookup_addr[31 -: TAG_W];
    assign lk_word    = lookup_addr[INST_W +: WORD_W];
    assign fill_index = fill.base[OFFSET_W +: INDEX_W];

    //////////////////////////////////////////////////
    // Lookup and fill
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            hit     <= 1'b0;
        end else begin
            if (fill.valid) begin
                valid_q[fill_index] <= 1'b1;
            end
            hit <= lookup_en && valid_q[lk_index] && (tag_mem[lk_index] == lk_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (fill.valid) begin
            tag_mem[fill_index]  <= fill.base[31 -: TAG_W];
            data_mem[fill_index] <= fill.data;
        end
        if (lookup_en) begin
            word <= data_mem[lk_index][lk_word*INST_BITS +: INST_BITS];
        end
    end

    // Refill base comes from fetch_unit
    a_fill_aligned: assert property (
        @(posedge clk) disable iff (rst)
        fill.valid |-> (fill.base[OFFSET_W-1:0] == '0)
    ) else $error("icache: fill base %h not block aligned", fill.base);

endmodule

/* rtl/pc_gen.sv */
`include "fetch_consts.svh"

module pc_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  fetch_pkg::redirect_t redirect_ext,
    input  fetch_pkg::redirect_t redirect_pd,
    input  logic                 pc_taken,
    output logic [31:0]          pc,
    output logic                 pc_valid
);

    logic [31:0] pc_next;

    always_comb begin
        pc_next = pc;
        if (redirect_ext.valid) begin
            pc_next = redirect_ext.target;     // Backend wins
        end else if (redirect_pd.valid) begin
            pc_next = redirect_pd.target;
        end else if (pc_taken) begin
            pc_next = pc + 32'(`FETCH_INST_BYTES);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc       <= `FETCH_RESET_PC;
            pc_valid <= 1'b0;
        end else begin
            pc       <= pc_next;
            pc_valid <= 1'b1;
        end
    end

    // Redirect targets from either source must keep fetch word aligned
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst)
        pc_valid |-> (pc[1:0] == 2'b00)
    ) else $error("pc_gen: misaligned pc %h", pc);

endmodule

/* rtl/predecode.sv */
module predecode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  fetch_pkg::fetch_out_t f_out,
    input  logic                  f_valid,
    output logic                  f_ready,
    output fetch_pkg::fetch_out_t dec_out,
    output logic                  dec_valid,
    input  logic                  dec_ready,
    output fetch_pkg::redirect_t  redirect_pd
);

    logic        is_jal;
    logic [31:0] jal_imm;

    // Wrong-path words are never taken in
    assign f_ready = (!dec_valid || dec_ready) && !flush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (f_valid && f_ready) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (f_valid && f_ready) dec_out <= f_out;
    end

    //////////////////////////////////////////////////
    // JAL detection
    //////////////////////////////////////////////////

    assign is_jal  = dec_out.inst.generic.opcode == fetch_pkg::OPC_JAL;
    assign jal_imm = {{11{dec_out.inst.jal.imm20}},
                      dec_out.inst.jal.imm20,
                      dec_out.inst.jal.imm19_12,
                      dec_out.inst.jal.imm11,
                      dec_out.inst.jal.imm10_1,
                      1'b0};

    // Pulse only on the handoff itself
    assign redirect_pd.valid  = dec_valid && dec_ready && is_jal && !dec_out.access_fault;
    assign redirect_pd.target = dec_out.pc + jal_imm;

endmodule

/* verification/tb_axi_mem.sv */
`include "fetch_consts.svh"

module tb_axi_mem (
    input  logic               clk,
    input  logic               rst,
    input  fetch_pkg::axi_ar_t ar,
    input  logic               arvalid,
    output logic               arready,
    output fetch_pkg::axi_r_t  r,
    output logic               rvalid,
    input  logic               rready
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] FAULT_BASE = `FETCH_RESET_PC + 32'h1000;

    int          seed = 17;
    logic [31:0] req_addr;
    logic [3:0]  req_id;

    function automatic logic [31:0] jal_encode(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    // ADDI with imm from A[11:2], registers folded from the upper bits
    function automatic logic [31:0] image_word(input logic [31:0] a);
        if (a == `FETCH_RESET_PC + 32'h1C) return jal_encode(21'h00_0024);
        if (a == `FETCH_RESET_PC + 32'h5C) return jal_encode(21'h1F_FFA4); // -0x5C
        return {2'b00, a[11:2], a[16:12] ^ a[26:22], 3'b000, a[21:17] ^ a[31:27],
                7'b0010011};
    endfunction

    //////////////////////////////////////////////////
    // One single-beat read at a time
    //////////////////////////////////////////////////

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        forever begin
            @(negedge clk);
            if (!rst && arvalid) begin
                repeat ($unsigned($random(seed)) % 3) @(negedge clk);
                arready  = 1'b1;
                req_addr = ar.addr;
                req_id   = ar.id;
                @(negedge clk);                 // AR taken on the edge before
                arready = 1'b0;
                repeat ($unsigned($random(seed)) % 4) @(negedge clk);
                r.data = (req_addr >= FAULT_BASE) ? 32'h0 : image_word(req_addr);
                r.resp = (req_addr >= FAULT_BASE) ? 2'b10 : 2'b00;   // SLVERR
                r.last = 1'b1;
                r.id   = req_id;
                rvalid = 1'b1;
                while (!rready) @(negedge clk);
                @(negedge clk);
                rvalid = 1'b0;
            end
        end
    end

endmodule

/* verification/tb_fetch_top.sv */
`include "fetch_consts.svh"

module tb_fetch_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] RESET_PC = `FETCH_RESET_PC;
    localparam int          TIMEOUT  = 4000;
    localparam logic [16:0] AR_ATTR  = {`FETCH_AXI_ID, 8'd0, 3'd2, 2'b01}; // One word, INCR

    logic                  clk = 1'b0;
    logic                  rst;
    fetch_pkg::redirect_t  redirect;
    fetch_pkg::axi_ar_t    ar;
    logic                  arvalid;
    logic                  arready;
    fetch_pkg::axi_r_t     r;
    logic                  rvalid;
    logic                  rready;
    fetch_pkg::fetch_out_t dec_out;
    logic                  dec_valid;
    logic                  dec_ready = 1'b0;

    int          seed = 17;
    int          ready_roll;
    int          cycles = 0;
    int          errors, errors_mark, tests_run, tests_failed;
    int          xfers, fault_xfers, xfer_base;
    logic        stall = 1'b0;
    logic        second_pass = 1'b0;
    logic        xfer;
    logic [31:0] exp_pc;
    logic [31:0] exp_word;
    logic        exp_fault;
    logic [16:0] ar_attr;
    string       test_name = "reset";

    always #5 clk = ~clk;

    fetch_top uut (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .dec_out   (dec_out),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready)
    );

    tb_axi_mem mem (
        .clk     (clk),
        .rst     (rst),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] jal_word(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic logic [31:0] expected_inst(input logic [31:0] a);
        if (a == RESET_PC + 32'h1C) return jal_word(21'h00_0024);
        if (a == RESET_PC + 32'h5C) return jal_word(21'h1F_FFA4);
        return {2'b00, a[11:2], a[16:12] ^ a[26:22], 3'b000, a[21:17] ^ a[31:27],
                7'b0010011};
    endfunction

    function automatic logic [31:0] next_pc(input logic [31:0] pc);
        if (pc == RESET_PC + 32'h1C) return RESET_PC + 32'h40;
        if (pc == RESET_PC + 32'h5C) return RESET_PC;
        return pc + 32'd4;
    endfunction

    // Blocks that hold the loop body
    function automatic logic in_loop(input logic [31:0] a);
        logic [31:0] off;
        off = a - RESET_PC;
        return (off < 32'h20) || (off >= 32'h40 && off < 32'h60);
    endfunction

    assign xfer      = dec_valid && dec_ready;
    assign exp_word  = expected_inst(exp_pc);
    assign exp_fault = exp_pc >= RESET_PC + 32'h1000;
    assign ar_attr   = {ar.id, ar.len, ar.size, ar.burst};

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_pc      <= RESET_PC;
            xfers       <= 0;
            fault_xfers <= 0;
        end else if (redirect.valid) begin
            exp_pc <= redirect.target;
        end else if (xfer) begin
            exp_pc      <= next_pc(exp_pc);
            xfers       <= xfers + 1;
            fault_xfers <= fault_xfers + (dec_out.access_fault ? 1 : 0);
        end
    end

    always @(negedge clk) begin
        ready_roll = $random(seed);
        dec_ready  = !stall && (ready_roll % 4 != 0);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("Timeout after %0d cycles, stuck in test %s", cycles, test_name);
            $display("Result: FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic value_error(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        errors++;
        $display("FAILED %s: %s expected %h, actual %h", test_name, what, expected, actual);
    endtask

    task automatic event_error(input string msg);
        errors++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    a_pc: assert property (@(posedge clk) disable iff (rst) xfer |-> dec_out.pc == exp_pc)
        else value_error("pc", $sampled(exp_pc), $sampled(dec_out.pc));

    a_inst: assert property (
        @(posedge clk) disable iff (rst)
        xfer && !exp_fault |-> dec_out.inst == exp_word
    ) else value_error("inst", $sampled(exp_word), $sampled(dec_out.inst));

    a_fault: assert property (
        @(posedge clk) disable iff (rst)
        xfer |-> dec_out.access_fault == exp_fault
    ) else value_error("access_fault", 32'($sampled(exp_fault)),
                       32'($sampled(dec_out.access_fault)));

    a_hold: assert property (
        @(posedge clk) disable iff (rst)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_out)
    ) else event_error("decode output changed while decode was stalled");

    a_ar_attr: assert property (
        @(posedge clk) disable iff (rst)
        arvalid |-> ar_attr == AR_ATTR
    ) else value_error("ar id/len/size/burst", 32'(AR_ATTR), 32'($sampled(ar_attr)));

    a_hits: assert property (
        @(posedge clk) disable iff (rst)
        second_pass && arvalid && arready |-> !in_loop(ar.addr)
    ) else event_error($sformatf("loop block refetched at %h", $sampled(ar.addr)));

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic begin_test(input string name);
        test_name   = name;
        errors_mark = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != errors_mark) tests_failed++;
        $display("%-16s done, %0d errors", test_name, errors - errors_mark);
    endtask

    task automatic wait_xfers(input int n);
        while (xfers < n) @(negedge clk);
    endtask

    // Only while decode is empty, so no older word can still transfer
    task automatic send_redirect(input logic [31:0] target);
        @(negedge clk);
        while (dec_valid) @(negedge clk);
        redirect.valid  = 1'b1;
        redirect.target = target;
        @(negedge clk);
        redirect = '0;
    endtask

    initial begin
        rst          = 1'b1;
        redirect     = '0;
        errors       = 0;
        errors_mark  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        begin_test("reset_pc");
        wait_xfers(1);
        end_test();
        begin_test("sequential");
        wait_xfers(8);
        end_test();
        begin_test("jal_redirect");
        wait_xfers(17);         // Through RESET_PC+0x5C and back
        end_test();

        begin_test("cache_hit");
        second_pass <= 1'b1;
        wait_xfers(33);
        second_pass <= 1'b0;
        end_test();

        begin_test("back_pressure");
        stall <= 1'b1;
        repeat (12) @(negedge clk);
        stall <= 1'b0;
        wait_xfers(45);
        end_test();

        begin_test("redirect_fault");
        send_redirect(RESET_PC + 32'h1000);
        while (fault_xfers < 1) @(negedge clk);
        send_redirect(RESET_PC);
        xfer_base = xfers;
        wait_xfers(xfer_base + 4);
        end_test();

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
